//--- ex_lsu_golden.txt
# inputs: stall flush valid pc op op_valid rs rt imm rd, then expected: commit_valid commit_pc
# w_reg_ena w_reg_dst w_data mem_ena mem_we mem_sel mem_addr mem_wdata exc_valid exc_code (hex)
0 0 0 0 0 1 0 0 0 0     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 100 0 1 5 7 0 3     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 104 2 1 3 a 0 4     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 108 0 1 7fffffff 1 0 5     1 100 1 3 c 0 0 0 0 0 0 0
0 0 1 10c 4 1 ff0 0ff 0 6     1 104 1 4 fffffff9 0 0 0 0 0 0 0
0 0 1 110 8 1 1000 0 8 8     1 108 0 0 0 0 0 0 0 0 1 c
0 0 1 114 9 1 1000 0 6 9     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 118 a 1 1000 0 fffd a     1 110 1 8 1008 1 0 f 1008 0 0 0
0 0 1 11c b 1 2000 deadbeef 4 0     1 114 1 9 1006 1 0 c 1006 0 0 0
0 0 1 120 c 1 2000 1234abcd 2 0     1 118 1 a ffd 1 0 2 ffd 0 0 0
0 0 1 124 d 1 2000 55 3 0     1 11c 0 0 0 1 1 f 2004 deadbeef 0 0
0 0 1 128 8 1 2000 0 2 b     1 120 0 0 0 1 1 c 2002 abcdabcd 0 0
0 0 1 12c 5 1 f0 f 0 7     1 124 0 0 0 1 1 8 2003 55555555 0 0
0 0 1 130 c 1 2000 0 1 0     1 128 0 0 0 0 0 0 0 0 1 4
0 0 1 134 2 1 80000000 1 0 1     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 138 e 1 0 0 0 0     1 130 0 0 0 0 0 0 0 0 1 5
0 0 0 0 0 1 0 0 0 0     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 13c f 1 0 0 0 0     1 138 0 0 0 0 0 0 0 0 1 8
0 0 0 0 0 1 0 0 0 0     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 140 0 0 7fffffff 1 0 2     1 13c 0 0 0 0 0 0 0 0 1 9
0 0 0 0 0 1 0 0 0 0     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 144 3 1 a 3 0 c     1 140 0 0 0 0 0 0 0 0 1 a
1 1 1 148 6 1 f 5 0 d     0 0 0 0 0 0 0 0 0 0 0 0
0 0 1 148 6 1 f 5 0 d     0 0 0 0 0 0 0 0 0 0 0 0
0 1 1 14c 7 1 ffffffff 1 0 e     1 144 1 c 7 0 0 0 0 0 0 0
0 0 1 150 5 1 1 2 0 f     1 148 1 d a 0 0 0 0 0 0 0 0
0 0 0 0 0 1 0 0 0 0     0 0 0 0 0 0 0 0 0 0 0 0
0 0 0 0 0 1 0 0 0 0     1 150 1 f 3 0 0 0 0 0 0 0

//--- list.f
cpu_pkg.sv
stage_if.sv
lsu_req_if.sv
alu_exec.sv
ex_lsu_reg.sv
lsu_addr_check.sv
commit_stage.sv
ex_lsu_top.sv
tb_ex_lsu_assertions.sv
tb_ex_lsu.sv

//--- Makefile
TOP := tb_ex_lsu

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): list.f $(wildcard *.sv)
	verilator --binary --timing --assert --timescale 1ns/10ps --top-module $(TOP) -f list.f

lint:
	verilator --lint-only --timing --assert -Wall --timescale 1ns/10ps --top-module $(TOP) -f list.f

clean:
	rm -rf obj_dir

//--- tb_ex_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_lsu import cpu_pkg::*; ();

    localparam string GOLDEN = "ex_lsu_golden.txt";

    logic              clk;
    logic              rst_n_i;
    logic              stall_i;
    logic              flush_i;
    logic              valid_i;
    logic [XLEN-1:0]   pc_i;
    alu_op_e           op_i;
    logic              op_valid_i;
    logic [XLEN-1:0]   rs_data_i;
    logic [XLEN-1:0]   rt_data_i;
    logic [IMM_W-1:0]  imm_i;
    logic [REG_AW-1:0] rd_i;
    logic              commit_valid_o;
    logic [XLEN-1:0]   commit_pc_o;
    logic              w_reg_ena_o;
    logic [REG_AW-1:0] w_reg_dst_o;
    logic [XLEN-1:0]   w_data_o;
    logic              mem_ena_o;
    logic              mem_we_o;
    logic [3:0]        mem_sel_o;
    logic [XLEN-1:0]   mem_addr_o;
    logic [XLEN-1:0]   mem_wdata_o;
    logic              exc_valid_o;
    exc_code_e         exc_code_o;
    logic [XLEN-1:0]   epc_o;

    logic [3:0]        op_v;       // Raw opcode column.
    logic              e_cv;
    logic [XLEN-1:0]   e_cpc;      // Also the expected epc.
    logic              e_wen;
    logic [REG_AW-1:0] e_wdst;
    logic [XLEN-1:0]   e_wdata;
    logic              e_men;
    logic              e_mwe;
    logic [3:0]        e_msel;
    logic [XLEN-1:0]   e_maddr;
    logic [XLEN-1:0]   e_mwdata;
    logic              e_exv;
    logic [4:0]        e_exc;

    int cycles = 0;
    int limit  = 0;
    int checks = 0;

    ex_lsu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the golden stimulus did not finish", cycles);
            abort_run();
        end
    end

    // ************************************************************
    // Checks
    // ************************************************************
    task automatic abort_run();
        $display("sim failed");
        $fatal(1, "Run stopped at the first failure.");
    endtask

    task automatic check_commit(input string name, input logic [XLEN-1:0] got,
                                input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_exc(input exc_code_e got, input exc_code_e exp);
        if (got !== exp) begin
            $display("Error at %0t: exc_code_o is %0d, expected %0d", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mem(input logic [3:0] sel, input logic [3:0] sel_exp,
                             input logic [XLEN-1:0] addr, input logic [XLEN-1:0] addr_exp,
                             input logic [XLEN-1:0] data, input logic [XLEN-1:0] data_exp);
        if (sel !== sel_exp) begin
            $display("Error at %0t: mem_sel_o is %h, expected %h", $time, sel, sel_exp);
            abort_run();
        end else if (addr !== addr_exp) begin
            $display("Error at %0t: mem_addr_o is %h, expected %h", $time, addr, addr_exp);
            abort_run();
        end else if (data !== data_exp) begin
            $display("Error at %0t: mem_wdata_o is %h, expected %h", $time, data, data_exp);
            abort_run();
        end
    endtask

    task automatic compare_outputs();
        check_commit("commit_valid_o", XLEN'(commit_valid_o), XLEN'(e_cv));
        check_commit("w_reg_ena_o", XLEN'(w_reg_ena_o), XLEN'(e_wen));
        check_commit("mem_ena_o", XLEN'(mem_ena_o), XLEN'(e_men));
        check_commit("mem_we_o", XLEN'(mem_we_o), XLEN'(e_mwe));
        check_commit("exc_valid_o", XLEN'(exc_valid_o), XLEN'(e_exv));
        check_exc(exc_code_o, exc_code_e'(e_exc));
        if (e_cv) check_commit("commit_pc_o", commit_pc_o, e_cpc);
        if (e_wen) begin
            check_commit("w_reg_dst_o", XLEN'(w_reg_dst_o), XLEN'(e_wdst));
            check_commit("w_data_o", w_data_o, e_wdata);
        end
        if (e_men) check_mem(mem_sel_o, e_msel, mem_addr_o, e_maddr, mem_wdata_o, e_mwdata);
        if (e_exv) check_commit("epc_o", epc_o, e_cpc);   // EPC is the faulting pc.
    endtask

    function automatic bit is_data_line(string s);
        return (s.len() > 1) && (s.getc(0) != "#");
    endfunction

    // ************************************************************
    // Stimulus
    // ************************************************************
    initial begin
        int    fd;
        int    fields;
        int    lines;
        string text;

        $timeformat(-9, 0, " ns", 0);
        stall_i    = 1'b0;
        flush_i    = 1'b0;
        valid_i    = 1'b0;
        pc_i       = '0;
        op_i       = OP_ADD;
        op_valid_i = 1'b1;
        rs_data_i  = '0;
        rt_data_i  = '0;
        imm_i      = '0;
        rd_i       = '0;
        rst_n_i    = 1'b0;

        lines = 0;
        fd = $fopen(GOLDEN, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN);
            abort_run();
        end
        while ($fgets(text, fd) != 0) begin
            if (is_data_line(text)) lines++;
        end
        $fclose(fd);
        limit = 2 * lines + 20;

        repeat (4) @(posedge clk);
        #1 rst_n_i = 1'b1;

        fd = $fopen(GOLDEN, "r");
        while ($fgets(text, fd) != 0) begin
            if (is_data_line(text)) begin
                @(posedge clk);
                #1;
                fields = $sscanf(text,
                    "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    stall_i, flush_i, valid_i, pc_i, op_v, op_valid_i,
                    rs_data_i, rt_data_i, imm_i, rd_i,
                    e_cv, e_cpc, e_wen, e_wdst, e_wdata, e_men,
                    e_mwe, e_msel, e_maddr, e_mwdata, e_exv, e_exc);
                if (fields != 22) begin
                    $display("Golden line has %0d fields instead of 22: %s", fields, text);
                    abort_run();
                end
                op_i = alu_op_e'(op_v);
                compare_outputs();   // Outputs come from the edge just passed.
                checks++;
            end
        end
        $fclose(fd);

        if (checks > 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("The golden file held no lines to check");
            abort_run();
        end
    end

endmodule

`default_nettype wire

//--- tb_ex_lsu_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module tb_ex_lsu_assertions import cpu_pkg::*; (
    input logic            clk,
    input logic            rst_n_i,
    input logic            stall_i,
    input logic            exc_flush_i,
    input logic            reg_valid_i,
    input logic [XLEN-1:0] reg_pc_i,
    input logic            exc_valid_i,
    input logic            w_reg_ena_i,
    input logic            mem_ena_i
);

    hold_on_stall: assert property (@(posedge clk) disable iff (!rst_n_i)
        stall_i && reg_valid_i |=> $stable(reg_valid_i) && $stable(reg_pc_i))
        else $error("ex_lsu_reg changed while stalled");

    clear_on_exc_flush: assert property (@(posedge clk) disable iff (!rst_n_i)
        exc_flush_i |=> !reg_valid_i)
        else $error("ex_lsu_reg still valid after exception flush");

    // A faulting instruction writes nothing.
    no_side_effect_on_exc: assert property (@(posedge clk) disable iff (!rst_n_i)
        exc_valid_i |-> !w_reg_ena_i && !mem_ena_i)
        else $error("Exception retired with a register write or memory request");

endmodule

bind ex_lsu_top tb_ex_lsu_assertions u_assertions (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .stall_i     (stall_i),
    .exc_flush_i (exc_flush),
    .reg_valid_i (lsu1_if.valid),
    .reg_pc_i    (lsu1_if.pc),
    .exc_valid_i (exc_valid_o),
    .w_reg_ena_i (w_reg_ena_o),
    .mem_ena_i   (mem_ena_o)
);

`default_nettype wire

//--- ex_lsu_top.sv
`timescale 1ns/10ps
`default_nettype none

module ex_lsu_top import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    input  logic              flush_i,
    input  logic              valid_i,
    input  logic [XLEN-1:0]   pc_i,
    input  alu_op_e           op_i,
    input  logic              op_valid_i,
    input  logic [XLEN-1:0]   rs_data_i,
    input  logic [XLEN-1:0]   rt_data_i,
    input  logic [IMM_W-1:0]  imm_i,
    input  logic [REG_AW-1:0] rd_i,
    output logic              commit_valid_o,
    output logic [XLEN-1:0]   commit_pc_o,
    output logic              w_reg_ena_o,
    output logic [REG_AW-1:0] w_reg_dst_o,
    output logic [XLEN-1:0]   w_data_o,
    output logic              mem_ena_o,
    output logic              mem_we_o,
    output logic [3:0]        mem_sel_o,
    output logic [XLEN-1:0]   mem_addr_o,
    output logic [XLEN-1:0]   mem_wdata_o,
    output logic              exc_valid_o,
    output exc_code_e         exc_code_o,
    output logic [XLEN-1:0]   epc_o
);

    logic exc_flush;

    stage_if   ex_if ();
    stage_if   lsu1_if ();
    lsu_req_if req_if ();

    alu_exec u_alu_exec (
        .valid_i    (valid_i),
        .pc_i       (pc_i),
        .op_i       (op_i),
        .op_valid_i (op_valid_i),
        .rs_data_i  (rs_data_i),
        .rt_data_i  (rt_data_i),
        .imm_i      (imm_i),
        .rd_i       (rd_i),
        .ex_o       (ex_if)
    );

    ex_lsu_reg u_ex_lsu_reg (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .stall_i     (stall_i),
        .flush_i     (flush_i),
        .exc_flush_i (exc_flush),
        .ex_i        (ex_if),
        .lsu1_o      (lsu1_if)
    );

    lsu_addr_check u_lsu_addr_check (
        .lsu1_i (lsu1_if),
        .req_o  (req_if)
    );

    commit_stage u_commit_stage (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .stall_i        (stall_i),
        .req_i          (req_if),
        .exc_flush_o    (exc_flush),
        .commit_valid_o (commit_valid_o),
        .commit_pc_o    (commit_pc_o),
        .w_reg_ena_o    (w_reg_ena_o),
        .w_reg_dst_o    (w_reg_dst_o),
        .w_data_o       (w_data_o),
        .mem_ena_o      (mem_ena_o),
        .mem_we_o       (mem_we_o),
        .mem_sel_o      (mem_sel_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .exc_valid_o    (exc_valid_o),
        .exc_code_o     (exc_code_o),
        .epc_o          (epc_o)
    );

endmodule

`default_nettype wire

//--- commit_stage.sv
`timescale 1ns/10ps
`default_nettype none

module commit_stage import cpu_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              stall_i,
    lsu_req_if.sink           req_i,
    output logic              exc_flush_o,
    output logic              commit_valid_o,
    output logic [XLEN-1:0]   commit_pc_o,
    output logic              w_reg_ena_o,
    output logic [REG_AW-1:0] w_reg_dst_o,
    output logic [XLEN-1:0]   w_data_o,
    output logic              mem_ena_o,
    output logic              mem_we_o,
    output logic [3:0]        mem_sel_o,
    output logic [XLEN-1:0]   mem_addr_o,
    output logic [XLEN-1:0]   mem_wdata_o,
    output logic              exc_valid_o,
    output exc_code_e         exc_code_o,
    output logic [XLEN-1:0]   epc_o
);

    logic       retire;
    logic       exc_hit;
    logic       do_mem;
    exc_code_e  exc_code;

    // A stalled cycle retires nothing.
    assign retire  = req_i.valid & !stall_i;
    assign exc_hit = retire & (|req_i.flags);
    assign do_mem  = retire & !exc_hit & req_i.mem_ena;

    assign exc_flush_o = exc_hit;

    // ************************************************************
    // Exception priority: RI, SYS, BP, OV, ADEL, ADES
    // ************************************************************
    always_comb begin
        if (req_i.flags.ri)        exc_code = EXC_RI;
        else if (req_i.flags.sys)  exc_code = EXC_SYS;
        else if (req_i.flags.bp)   exc_code = EXC_BP;
        else if (req_i.flags.ov)   exc_code = EXC_OV;
        else if (req_i.flags.adel) exc_code = EXC_ADEL;
        else if (req_i.flags.ades) exc_code = EXC_ADES;
        else                       exc_code = EXC_NONE;
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            commit_valid_o <= 1'b0;
            w_reg_ena_o    <= 1'b0;
            mem_ena_o      <= 1'b0;
            mem_we_o       <= 1'b0;
            exc_valid_o    <= 1'b0;
            exc_code_o     <= EXC_NONE;
            epc_o          <= '0;
        end else begin
            commit_valid_o <= retire;
            w_reg_ena_o    <= retire & !exc_hit & req_i.w_reg_ena;   // Killed by exception.
            mem_ena_o      <= do_mem;
            mem_we_o       <= do_mem & req_i.mem_we;
            exc_valid_o    <= exc_hit;
            exc_code_o     <= exc_hit ? exc_code : EXC_NONE;
            if (exc_hit) begin
                epc_o <= req_i.pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        commit_pc_o <= req_i.pc;
        w_reg_dst_o <= req_i.w_reg_dst;
        w_data_o    <= req_i.w_data;
        mem_sel_o   <= req_i.mem_sel;
        mem_addr_o  <= req_i.mem_addr;
        mem_wdata_o <= req_i.mem_wdata;
    end

endmodule

`default_nettype wire

//--- lsu_addr_check.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_addr_check import cpu_pkg::*; (
    stage_if.sink      lsu1_i,
    lsu_req_if.source  req_o
);

    mem_size_e       size;
    logic            is_load;
    logic            is_store;
    logic [1:0]      byte_off;
    logic            misaligned;
    logic [3:0]      sel;
    logic [XLEN-1:0] wdata;
    exc_flags_t      flags;

    assign size     = op_mem_size(lsu1_i.op);
    assign is_load  = op_is_load(lsu1_i.op);
    assign is_store = op_is_store(lsu1_i.op);
    assign byte_off = lsu1_i.result[1:0];

    assign misaligned = ((size == SIZE_HALF) && byte_off[0]) ||
                        ((size == SIZE_WORD) && (byte_off != 2'b00));

    // ************************************************************
    // Lane select and store data steering
    // ************************************************************
    always_comb begin
        case (size)
            SIZE_BYTE: begin
                sel   = 4'b0001 << byte_off;
                wdata = {4{lsu1_i.rt_data[7:0]}};      // Byte on every lane.
            end
            SIZE_HALF: begin
                sel   = byte_off[1] ? 4'b1100 : 4'b0011;
                wdata = {2{lsu1_i.rt_data[15:0]}};
            end
            default: begin
                sel   = 4'b1111;
                wdata = lsu1_i.rt_data;
            end
        endcase
    end

    always_comb begin
        flags      = lsu1_i.flags;
        flags.adel = lsu1_i.flags.adel | (is_load & misaligned);
        flags.ades = lsu1_i.flags.ades | (is_store & misaligned);
    end

    assign req_o.valid     = lsu1_i.valid;
    assign req_o.pc        = lsu1_i.pc;
    assign req_o.mem_ena   = lsu1_i.valid & (is_load | is_store);
    assign req_o.mem_we    = lsu1_i.valid & is_store;
    assign req_o.mem_sel   = sel;
    assign req_o.mem_addr  = lsu1_i.result;
    assign req_o.mem_wdata = wdata;
    assign req_o.w_reg_ena = lsu1_i.w_reg_ena;
    assign req_o.w_reg_dst = lsu1_i.w_reg_dst;
    assign req_o.w_data    = lsu1_i.result;        // Load data arrives in a later stage.
    assign req_o.flags     = flags;

endmodule

`default_nettype wire

//--- ex_lsu_reg.sv
`timescale 1ns/10ps
`default_nettype none

module ex_lsu_reg import cpu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  logic     exc_flush_i,
    stage_if.sink    ex_i,
    stage_if.source  lsu1_o
);

    logic load;

    assign load = !stall_i && !flush_i && !exc_flush_i;

    // ************************************************************
    // Valid bit: reset, exception flush, branch flush, stall
    // ************************************************************
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lsu1_o.valid <= 1'b0;
        end else if (exc_flush_i) begin
            lsu1_o.valid <= 1'b0;
        end else if (flush_i && !stall_i) begin
            lsu1_o.valid <= 1'b0;                      // Bubble.
        end else if (!stall_i) begin
            lsu1_o.valid <= ex_i.valid;
        end
    end

    // Payload follows valid, held otherwise.
    always_ff @(posedge clk) begin
        if (load) begin
            lsu1_o.pc        <= ex_i.pc;
            lsu1_o.op        <= ex_i.op;
            lsu1_o.result    <= ex_i.result;
            lsu1_o.rt_data   <= ex_i.rt_data;
            lsu1_o.w_reg_ena <= ex_i.w_reg_ena;
            lsu1_o.w_reg_dst <= ex_i.w_reg_dst;
            lsu1_o.flags     <= ex_i.flags;
        end
    end

endmodule

`default_nettype wire

//--- alu_exec.sv
`timescale 1ns/10ps
`default_nettype none

module alu_exec import cpu_pkg::*; (
    input  logic              valid_i,
    input  logic [XLEN-1:0]   pc_i,
    input  alu_op_e           op_i,
    input  logic              op_valid_i,
    input  logic [XLEN-1:0]   rs_data_i,
    input  logic [XLEN-1:0]   rt_data_i,
    input  logic [IMM_W-1:0]  imm_i,
    input  logic [REG_AW-1:0] rd_i,
    stage_if.source           ex_o
);

    logic [XLEN-1:0] imm_sext;
    logic [XLEN-1:0] sum;
    logic [XLEN-1:0] diff;
    logic            add_ov;
    logic            sub_ov;
    logic            slt;
    logic [XLEN-1:0] result;
    logic            writes_reg;
    exc_flags_t      flags;

    assign imm_sext = {{(XLEN-IMM_W){imm_i[IMM_W-1]}}, imm_i};
    assign sum      = rs_data_i + rt_data_i;
    assign diff     = rs_data_i - rt_data_i;
    assign slt      = $signed(rs_data_i) < $signed(rt_data_i);

    // Signed overflow from operand and result sign bits.
    assign add_ov = (rs_data_i[XLEN-1] == rt_data_i[XLEN-1]) &&
                    (sum[XLEN-1] != rs_data_i[XLEN-1]);
    assign sub_ov = (rs_data_i[XLEN-1] != rt_data_i[XLEN-1]) &&
                    (diff[XLEN-1] != rs_data_i[XLEN-1]);

    always_comb begin
        result     = '0;
        writes_reg = 1'b1;
        case (op_i)
            OP_ADD, OP_ADDU:    result = sum;
            OP_SUB, OP_SUBU:    result = diff;
            OP_AND:             result = rs_data_i & rt_data_i;
            OP_OR:              result = rs_data_i | rt_data_i;
            OP_XOR:             result = rs_data_i ^ rt_data_i;
            OP_SLT:             result = {{(XLEN-1){1'b0}}, slt};
            OP_LW, OP_LH, OP_LB: result = rs_data_i + imm_sext;
            OP_SW, OP_SH, OP_SB: begin
                result     = rs_data_i + imm_sext;
                writes_reg = 1'b0;
            end
            default:            writes_reg = 1'b0;  // SYSCALL and BREAK.
        endcase
    end

    always_comb begin
        flags      = '0;
        flags.ri   = valid_i & ~op_valid_i;
        flags.sys  = valid_i & (op_i == OP_SYSCALL);
        flags.bp   = valid_i & (op_i == OP_BREAK);
        flags.ov   = valid_i & (((op_i == OP_ADD) & add_ov) | ((op_i == OP_SUB) & sub_ov));
    end

    assign ex_o.valid     = valid_i;
    assign ex_o.pc        = pc_i;
    assign ex_o.op        = op_i;
    assign ex_o.result    = result;
    assign ex_o.rt_data   = rt_data_i;
    assign ex_o.w_reg_ena = valid_i & writes_reg & (rd_i != '0);  // r0 is never written.
    assign ex_o.w_reg_dst = rd_i;
    assign ex_o.flags     = flags;

endmodule

`default_nettype wire

//--- lsu_req_if.sv
`timescale 1ns/10ps
`default_nettype none

interface lsu_req_if import cpu_pkg::*; ();

    logic              valid;
    logic [XLEN-1:0]   pc;
    logic              mem_ena;
    logic              mem_we;
    logic [3:0]        mem_sel;    // Little-endian byte lanes.
    logic [XLEN-1:0]   mem_addr;
    logic [XLEN-1:0]   mem_wdata;
    logic              w_reg_ena;
    logic [REG_AW-1:0] w_reg_dst;
    logic [XLEN-1:0]   w_data;
    exc_flags_t        flags;      // All exceptions seen so far.

    modport source (
        output valid, pc, mem_ena, mem_we, mem_sel, mem_addr, mem_wdata,
               w_reg_ena, w_reg_dst, w_data, flags
    );

    modport sink (
        input  valid, pc, mem_ena, mem_we, mem_sel, mem_addr, mem_wdata,
               w_reg_ena, w_reg_dst, w_data, flags
    );

endinterface

`default_nettype wire

//--- stage_if.sv
`timescale 1ns/10ps
`default_nettype none

interface stage_if import cpu_pkg::*; ();

    logic              valid;
    logic [XLEN-1:0]   pc;
    alu_op_e           op;
    logic [XLEN-1:0]   result;     // ALU value or effective address.
    logic [XLEN-1:0]   rt_data;    // Store data source.
    logic              w_reg_ena;
    logic [REG_AW-1:0] w_reg_dst;
    exc_flags_t        flags;

    modport source (
        output valid, pc, op, result, rt_data, w_reg_ena, w_reg_dst, flags
    );

    modport sink (
        input  valid, pc, op, result, rt_data, w_reg_ena, w_reg_dst, flags
    );

endinterface

`default_nettype wire

//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // ************************************************************
    // Widths
    // ************************************************************
    localparam int unsigned XLEN   = 32;  // Data and address width.
    localparam int unsigned REG_AW = 5;   // Register number width.
    localparam int unsigned IMM_W  = 16;  // I-type immediate width.

    // ************************************************************
    // Encodings
    // ************************************************************
    typedef enum logic [3:0] {
        OP_ADD, OP_ADDU, OP_SUB, OP_SUBU,
        OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_LW, OP_LH, OP_LB, OP_SW,
        OP_SH, OP_SB, OP_SYSCALL, OP_BREAK
    } alu_op_e;

    // MIPS cause register ExcCode values.
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_SYS  = 5'd8,
        EXC_BP   = 5'd9,
        EXC_RI   = 5'd10,
        EXC_OV   = 5'd12
    } exc_code_e;

    typedef struct packed {
        logic ri;
        logic sys;
        logic bp;
        logic ov;
        logic adel;
        logic ades;
    } exc_flags_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } mem_size_e;

    function automatic logic op_is_load(alu_op_e op);
        return (op == OP_LW) || (op == OP_LH) || (op == OP_LB);
    endfunction

    function automatic logic op_is_store(alu_op_e op);
        return (op == OP_SW) || (op == OP_SH) || (op == OP_SB);
    endfunction

    // Non-memory operations report a word so alignment stays quiet.
    function automatic mem_size_e op_mem_size(alu_op_e op);
        case (op)
            OP_LB, OP_SB: return SIZE_BYTE;
            OP_LH, OP_SH: return SIZE_HALF;
            default:      return SIZE_WORD;
        endcase
    endfunction

endpackage

`default_nettype wire
